/* dualCoreDefs_defs.svh */
`ifndef DUAL_CORE_DEFS_SVH
`define DUAL_CORE_DEFS_SVH

// data and instruction word width
`define DATA_WIDTH 8

// ram address width, 256 bytes per ram
`define ADDR_WIDTH 8

// per-core program and data window
// core n owns n*PROG_WINDOW .. n*PROG_WINDOW+PROG_WINDOW-1
`define PROG_WINDOW 32

// arbiter requesters: core 0, core 1, host last
`define NUM_REQ 3

// busy-cycle counter width
`define CNT_WIDTH 32

`endif

/* dualCorePkg.sv */
`include "dualCoreDefs_defs.svh"

package dualCorePkg;

	// request towards an arbiter
	// held steady by the requester until acq
	typedef struct packed {
		logic rden;
		logic wren;
		logic [`ADDR_WIDTH-1:0] address;
		logic [`DATA_WIDTH-1:0] data;
	} memReqT;

	// response from an arbiter
	// q is valid the cycle after a read acq
	typedef struct packed {
		logic acq;
		logic [`DATA_WIDTH-1:0] q;
	} memRspT;

	// core sequencing states
	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DECODE,
		MEMOP,
		HALTED
	} coreStateT;

	// opcode in the top 3 bits of an instruction
	typedef enum logic [2:0] {
		LOAD,
		STORE,
		ADD,
		SUB,
		AND,
		XOR,
		JNZ,
		HALT
	} opcodeT;

endpackage

/* syncRam.sv */
`include "dualCoreDefs_defs.svh"

module syncRam (
	input logic CLK,
	input logic [`ADDR_WIDTH-1:0] address,
	input logic [`DATA_WIDTH-1:0] data,
	input logic wren,
	output logic [`DATA_WIDTH-1:0] q
);

	localparam int depth = 2 ** `ADDR_WIDTH;

	// byte storage
	logic [`DATA_WIDTH-1:0] mem [depth];

	// write at the end of the cycle
	always_ff @(posedge CLK) begin
		if (wren) begin
			mem[address] <= data;
		end
	end

	// registered read, one cycle after address
	// old contents come back on a write cycle
	always_ff @(posedge CLK) begin
		q <= mem[address];
	end

endmodule

/* memArbiter.sv */
`include "dualCoreDefs_defs.svh"

module memArbiter
	import dualCorePkg::*;
#(
	parameter int NUM_REQ = `NUM_REQ
) (
	input logic CLK,
	input logic rstN,
	input logic run,
	input memReqT req [NUM_REQ],
	output memRspT rsp [NUM_REQ],
	output logic [`ADDR_WIDTH-1:0] ramAddress,
	output logic [`DATA_WIDTH-1:0] ramData,
	output logic ramWren,
	input logic [`DATA_WIDTH-1:0] ramQ
);

	localparam int idxWidth = $clog2(NUM_REQ);
	// host is always the last requester
	localparam int hostIdx = NUM_REQ - 1;

	logic [NUM_REQ-1:0] pending;
	logic [NUM_REQ-1:0] grantOh;
	logic [idxWidth-1:0] grantIdx;
	logic [idxWidth-1:0] lastGrant;
	logic [idxWidth-1:0] rdOwner;
	logic granted;
	logic rdValid;

	// eligible requesters, host masked while cores run
	always_comb begin
		for (int i = 0; i < NUM_REQ; i++) begin
			pending[i] = (req[i].rden | req[i].wren) & ~(i == hostIdx && run);
		end
	end

	// rotating priority, search starts just past last winner
	always_comb begin
		int cand;
		grantOh = '0;
		grantIdx = lastGrant;
		granted = 1'b0;
		for (int k = 1; k <= NUM_REQ; k++) begin
			cand = (int'(lastGrant) + k) % NUM_REQ;
			if (!granted && pending[cand]) begin
				granted = 1'b1;
				grantIdx = idxWidth'(cand);
			end
		end
		if (granted) begin
			grantOh[grantIdx] = 1'b1;
		end
	end

	// winner drives the ram port
	assign ramAddress = req[grantIdx].address;
	assign ramData = req[grantIdx].data;
	assign ramWren = granted & req[grantIdx].wren;

	// acq now, read data only to the owner of last cycle's read
	always_comb begin
		for (int i = 0; i < NUM_REQ; i++) begin
			rsp[i].acq = grantOh[i];
			rsp[i].q = (rdValid && rdOwner == idxWidth'(i)) ? ramQ : '0;
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			// core 0 first after reset
			lastGrant <= idxWidth'(hostIdx);
			rdValid <= 1'b0;
			rdOwner <= '0;
		end else begin
			rdValid <= granted & req[grantIdx].rden;
			if (granted) begin
				lastGrant <= grantIdx;
				rdOwner <= grantIdx;
			end
		end
	end

	// one ram access per cycle
	assert property (@(posedge CLK) disable iff (!rstN) $onehot0(grantOh));

endmodule

/* core.sv */
`include "dualCoreDefs_defs.svh"

module core
	import dualCorePkg::*;
#(
	parameter int coreId = 0
) (
	input logic CLK,
	input logic rstN,
	input logic go,
	output memReqT iReq,
	input memRspT iRsp,
	output memReqT dReq,
	input memRspT dRsp,
	output logic busy,
	output logic halted
);

	localparam int addrWidth = `ADDR_WIDTH;
	localparam int offWidth = $clog2(`PROG_WINDOW);
	// start of this core's window in both rams
	localparam logic [addrWidth-1:0] windowBase = addrWidth'(coreId * `PROG_WINDOW);

	coreStateT state;
	// pc is an offset, wraps inside the window
	logic [offWidth-1:0] pc;
	logic [`DATA_WIDTH-1:0] acc;
	logic [`DATA_WIDTH-1:0] instr;
	// set once data acq seen, q arrives next cycle
	logic dataPhase;
	opcodeT fetchedOp;
	opcodeT curOp;
	logic [offWidth-1:0] curOperand;

	// fetched word is on iRsp.q during DECODE
	assign fetchedOp = opcodeT'(iRsp.q[`DATA_WIDTH-1 -: 3]);
	// latched word for MEMOP
	assign curOp = opcodeT'(instr[`DATA_WIDTH-1 -: 3]);
	assign curOperand = instr[offWidth-1:0];

	// instruction side, read only
	always_comb begin
		iReq.rden = state == FETCH;
		iReq.wren = 1'b0;
		iReq.address = windowBase + addrWidth'(pc);
		iReq.data = '0;
	end

	// data side, one access per memory instruction
	always_comb begin
		dReq.rden = state == MEMOP && !dataPhase && curOp != STORE;
		dReq.wren = state == MEMOP && !dataPhase && curOp == STORE;
		dReq.address = windowBase + addrWidth'(curOperand);
		dReq.data = acc;
	end

	assign busy = state inside {FETCH, DECODE, MEMOP};
	assign halted = state == HALTED;

	// sequencer
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
			pc <= '0;
			dataPhase <= 1'b0;
		end else begin
			case (state)
				IDLE, HALTED: begin
					// restart from window base
					if (go) begin
						state <= FETCH;
						pc <= '0;
						dataPhase <= 1'b0;
					end
				end
				FETCH: begin
					if (iRsp.acq) begin
						state <= DECODE;
					end
				end
				DECODE: begin
					pc <= pc + 1'b1;
					case (fetchedOp)
						JNZ: begin
							// taken branch overrides the increment
							if (acc != '0) begin
								pc <= iRsp.q[offWidth-1:0];
							end
							state <= FETCH;
						end
						HALT: state <= HALTED;
						default: state <= MEMOP;
					endcase
				end
				MEMOP: begin
					if (dataPhase) begin
						dataPhase <= 1'b0;
						state <= FETCH;
					end else if (dRsp.acq) begin
						dataPhase <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// datapath
	always_ff @(posedge CLK) begin
		if (state == DECODE) begin
			instr <= iRsp.q;
		end
		if ((state == IDLE || state == HALTED) && go) begin
			acc <= '0;
		end else if (state == MEMOP && dataPhase) begin
			// read data valid now
			case (curOp)
				LOAD: acc <= dRsp.q;
				ADD: acc <= acc + dRsp.q;
				SUB: acc <= acc - dRsp.q;
				AND: acc <= acc & dRsp.q;
				XOR: acc <= acc ^ dRsp.q;
				default: acc <= acc;
			endcase
		end
	end

	// never read and write together
	assert property (@(posedge CLK) disable iff (!rstN) !(dReq.rden && dReq.wren));

	// requests held until the arbiter answers
	assert property (@(posedge CLK) disable iff (!rstN)
		(iReq.rden && !iRsp.acq) |=> $stable(iReq));
	assert property (@(posedge CLK) disable iff (!rstN)
		((dReq.rden || dReq.wren) && !dRsp.acq) |=> $stable(dReq));

endmodule

/* runControl.sv */
`include "dualCoreDefs_defs.svh"

module runControl (
	input logic CLK,
	input logic rstN,
	input logic start,
	input logic [1:0] busy,
	input logic [1:0] halted,
	output logic go,
	output logic run,
	output logic done,
	output logic [`CNT_WIDTH-1:0] cycleCount
);

	logic startD;
	logic startRise;

	// new start only counts when not already running
	assign startRise = start & ~startD & ~run;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			startD <= 1'b0;
			go <= 1'b0;
			run <= 1'b0;
			done <= 1'b0;
			cycleCount <= '0;
		end else begin
			startD <= start;
			// one-cycle pulse to both cores
			go <= startRise;
			if (startRise) begin
				done <= 1'b0;
				cycleCount <= '0;
			end else if (|busy) begin
				cycleCount <= cycleCount + 1'b1;
			end
			// run spans go to done
			if (go) begin
				run <= 1'b1;
			end else if (run && &halted) begin
				run <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// both cores sit halted while done, so the count holds
	assert property (@(posedge CLK) disable iff (!rstN)
		(done && !startRise) |=> $stable(cycleCount));

endmodule

/* dualCoreSystem.sv */
`include "dualCoreDefs_defs.svh"

module dualCoreSystem
	import dualCorePkg::*;
(
	input logic CLK,
	input logic rstN,
	input logic start,
	input memReqT hostIReq,
	output memRspT hostIRsp,
	input memReqT hostDReq,
	output memRspT hostDRsp,
	output logic done,
	output logic [`CNT_WIDTH-1:0] cycleCount
);

	localparam int hostIdx = `NUM_REQ - 1;

	// requester slots: core 0, core 1, host
	memReqT iReqs [`NUM_REQ];
	memRspT iRsps [`NUM_REQ];
	memReqT dReqs [`NUM_REQ];
	memRspT dRsps [`NUM_REQ];

	logic [`ADDR_WIDTH-1:0] iramAddress;
	logic [`ADDR_WIDTH-1:0] dramAddress;
	logic [`DATA_WIDTH-1:0] iramData;
	logic [`DATA_WIDTH-1:0] dramData;
	logic [`DATA_WIDTH-1:0] iramQ;
	logic [`DATA_WIDTH-1:0] dramQ;
	logic iramWren;
	logic dramWren;
	logic [1:0] coreBusy;
	logic [1:0] coreHalted;
	logic go;
	logic run;

	// host port on the last slot
	assign iReqs[hostIdx] = hostIReq;
	assign dReqs[hostIdx] = hostDReq;
	assign hostIRsp = iRsps[hostIdx];
	assign hostDRsp = dRsps[hostIdx];

	core #(.coreId(0)) core0 (
		.CLK(CLK), .rstN(rstN), .go(go),
		.iReq(iReqs[0]), .iRsp(iRsps[0]), .dReq(dReqs[0]), .dRsp(dRsps[0]),
		.busy(coreBusy[0]), .halted(coreHalted[0])
	);

	core #(.coreId(1)) core1 (
		.CLK(CLK), .rstN(rstN), .go(go),
		.iReq(iReqs[1]), .iRsp(iRsps[1]), .dReq(dReqs[1]), .dRsp(dRsps[1]),
		.busy(coreBusy[1]), .halted(coreHalted[1])
	);

	// instruction memory
	memArbiter #(.NUM_REQ(`NUM_REQ)) irammemc (
		.CLK(CLK), .rstN(rstN), .run(run), .req(iReqs), .rsp(iRsps),
		.ramAddress(iramAddress), .ramData(iramData), .ramWren(iramWren), .ramQ(iramQ)
	);

	syncRam iram (
		.CLK(CLK), .address(iramAddress), .data(iramData), .wren(iramWren), .q(iramQ)
	);

	// data memory
	memArbiter #(.NUM_REQ(`NUM_REQ)) drammemc (
		.CLK(CLK), .rstN(rstN), .run(run), .req(dReqs), .rsp(dRsps),
		.ramAddress(dramAddress), .ramData(dramData), .ramWren(dramWren), .ramQ(dramQ)
	);

	syncRam dram (
		.CLK(CLK), .address(dramAddress), .data(dramData), .wren(dramWren), .q(dramQ)
	);

	runControl runCtrl (
		.CLK(CLK), .rstN(rstN), .start(start), .busy(coreBusy), .halted(coreHalted),
		.go(go), .run(run), .done(done), .cycleCount(cycleCount)
	);

endmodule

/* tbClock.sv */
module tbClock (
	output logic CLK,
	output logic rstN
);

	// 10-unit period
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// reset held for 8 cycles, released away from the rising edge
	initial begin
		rstN = 1'b0;
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		rstN = 1'b1;
	end

endmodule

/* dualCoreChecker.sv */
`include "dualCoreDefs_defs.svh"

module dualCoreChecker
	import dualCorePkg::*;
(
	input logic CLK,
	input logic rstN,
	input memReqT hostIReq,
	input memRspT hostIRsp,
	input memReqT hostDReq,
	input memRspT hostDRsp,
	input logic go,
	input logic [1:0] halted,
	input logic done,
	input logic [`CNT_WIDTH-1:0] cycleCount,
	output int errorCount
);

	// images as loaded by the host, data image advanced by the model
	logic [7:0] iImage [256];
	logic [7:0] dImage [256];
	logic iRdPending;
	logic dRdPending;
	logic [7:0] iRdAddr;
	logic [7:0] dRdAddr;
	logic counting;
	logic doneDue;
	logic seenGo;
	int busyCycles;
	int errors = 0;

	assign errorCount = errors;

	// ISA reference, one core from its window base until HALT
	task automatic runModel(input int coreNum);
		int base;
		int pc;
		int steps;
		logic [7:0] acc;
		logic [7:0] word;
		logic [7:0] addr;
		logic stop;
		opcodeT op;
		base = coreNum * `PROG_WINDOW;
		pc = 0;
		steps = 0;
		acc = 8'h00;
		stop = 1'b0;
		while (!stop && steps < 4 * `PROG_WINDOW) begin
			word = iImage[8'(base + pc)];
			op = opcodeT'(word[7:5]);
			addr = 8'(base + int'(word[4:0]));
			// pc wraps inside the window
			pc = (pc + 1) % `PROG_WINDOW;
			steps++;
			case (op)
				LOAD: acc = dImage[addr];
				STORE: dImage[addr] = acc;
				ADD: acc = acc + dImage[addr];
				SUB: acc = acc - dImage[addr];
				AND: acc = acc & dImage[addr];
				XOR: acc = acc ^ dImage[addr];
				JNZ: begin
					if (acc != 8'h00) begin
						pc = int'(word[4:0]);
					end
				end
				default: stop = 1'b1;
			endcase
		end
	endtask

	task automatic compareRead(input string side, input logic [7:0] addr,
		input logic [7:0] got, input logic [7:0] expected);
		if (got !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s read of address %0d returned %02h, expected %02h",
				$time, side, addr, got, expected);
		end
	endtask

	always @(posedge CLK) begin
		if (!rstN) begin
			iRdPending = 1'b0;
			dRdPending = 1'b0;
			counting = 1'b0;
			doneDue = 1'b0;
			seenGo = 1'b0;
			busyCycles = 0;
		end else begin
			// q of last cycle's host read grants
			if (iRdPending) begin
				compareRead("iram", iRdAddr, hostIRsp.q, iImage[iRdAddr]);
			end
			if (dRdPending) begin
				compareRead("dram", dRdAddr, hostDRsp.q, dImage[dRdAddr]);
			end
			iRdPending = hostIRsp.acq && hostIReq.rden;
			iRdAddr = hostIReq.address;
			dRdPending = hostDRsp.acq && hostDReq.rden;
			dRdAddr = hostDReq.address;
			// host writes land at the end of the acq cycle
			if (hostIRsp.acq && hostIReq.wren) begin
				iImage[hostIReq.address] = hostIReq.data;
			end
			if (hostDRsp.acq && hostDReq.wren) begin
				dImage[hostDReq.address] = hostDReq.data;
			end
			// from the cycle after go up to the last halt
			if ((hostIRsp.acq || hostDRsp.acq) && counting) begin
				errors++;
				$display("host request was granted at %0t while the cores were running", $time);
			end
			if (!seenGo && done) begin
				errors++;
				$display("done was high at %0t before any start", $time);
			end
			// cycle after the last halt
			if (doneDue) begin
				doneDue = 1'b0;
				if (!done) begin
					errors++;
					$display("MISMATCH at %0t: done low one cycle after both cores halted", $time);
				end
				if (cycleCount !== `CNT_WIDTH'(busyCycles)) begin
					errors++;
					$display("MISMATCH at %0t: cycleCount %0d, expected %0d",
						$time, cycleCount, busyCycles);
				end
			end
			if (go) begin
				// final memory known from here on
				seenGo = 1'b1;
				counting = 1'b1;
				busyCycles = 0;
				runModel(0);
				runModel(1);
			end else if (counting) begin
				if (&halted) begin
					counting = 1'b0;
					doneDue = 1'b1;
					if (done) begin
						errors++;
						$display("MISMATCH at %0t: done high in the cycle of the last halt", $time);
					end
				end else begin
					busyCycles++;
				end
			end
		end
	end

endmodule

/* dualCoreSystemTb.sv */
`include "dualCoreDefs_defs.svh"

module dualCoreSystemTb
	import dualCorePkg::*;
();

	localparam int accessLimit = 2000;
	localparam int numRuns = 2;

	logic CLK;
	logic rstN;
	logic start;
	memReqT hostIReq;
	memReqT hostDReq;
	memRspT hostIRsp;
	memRspT hostDRsp;
	logic done;
	logic [`CNT_WIDTH-1:0] cycleCount;
	int errorCount;

	tbClock clockGen (.CLK(CLK), .rstN(rstN));

	dualCoreSystem DUT (
		.CLK(CLK), .rstN(rstN), .start(start),
		.hostIReq(hostIReq), .hostIRsp(hostIRsp), .hostDReq(hostDReq), .hostDRsp(hostDRsp),
		.done(done), .cycleCount(cycleCount)
	);

	dualCoreChecker monitor (
		.CLK(CLK), .rstN(rstN),
		.hostIReq(hostIReq), .hostIRsp(hostIRsp), .hostDReq(hostDReq), .hostDRsp(hostDRsp),
		.go(DUT.go), .halted(DUT.coreHalted),
		.done(done), .cycleCount(cycleCount), .errorCount(errorCount)
	);

	task automatic finishRun(input int timeouts);
		$display("closing counts: %0d check errors, %0d timeouts", errorCount, timeouts);
		if (errorCount == 0 && timeouts == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	// one host access, request held until acq
	task automatic hostAccess(input logic instrSide, input logic write,
		input logic [7:0] address, input logic [7:0] data);
		memReqT req;
		int cycles;
		logic seen;
		req.rden = ~write;
		req.wren = write;
		req.address = address;
		req.data = data;
		cycles = 0;
		seen = 1'b0;
		@(negedge CLK);
		if (instrSide) begin
			hostIReq = req;
		end else begin
			hostDReq = req;
		end
		while (!seen) begin
			@(posedge CLK);
			seen = instrSide ? hostIRsp.acq : hostDRsp.acq;
			cycles++;
			if (!seen && cycles > accessLimit) begin
				$display("timeout: host access to address %0d never got acq", address);
				finishRun(1);
			end
		end
		@(negedge CLK);
		hostIReq = '0;
		hostDReq = '0;
	endtask

	// program in offsets 0-15, data in 16-31
	task automatic loadWindow(input int coreNum);
		int base;
		int op;
		logic [7:0] word;
		base = coreNum * `PROG_WINDOW;
		for (int i = 0; i < 16; i++) begin
			op = int'($urandom_range(6, 0));
			if (i == 15) begin
				word = {HALT, 5'd0};
			end else if (op == int'(JNZ)) begin
				// forward only, so every run reaches HALT
				word = {3'(op), 5'($urandom_range(15, i + 1))};
			end else begin
				word = {3'(op), 5'($urandom_range(31, 16))};
			end
			hostAccess(1'b1, 1'b1, 8'(base + i), word);
			hostAccess(1'b0, 1'b1, 8'(base + 16 + i), 8'($urandom));
		end
	endtask

	task automatic readRange(input logic instrSide, input int first, input int count);
		for (int i = 0; i < count; i++) begin
			hostAccess(instrSide, 1'b0, 8'(first + i), 8'h00);
		end
	endtask

	task automatic pulseStart();
		@(negedge CLK);
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
	endtask

	task automatic waitDone();
		int cycles;
		cycles = 0;
		while (!done) begin
			@(posedge CLK);
			cycles++;
			if (cycles > accessLimit) begin
				$display("timeout: done never rose after start");
				finishRun(1);
			end
		end
	endtask

	initial begin
		int cycles;
		void'($urandom(32'ha2c4));
		start = 1'b0;
		hostIReq = '0;
		hostDReq = '0;
		cycles = 0;
		// rstN may still be unknown at time zero
		while (rstN !== 1'b1) begin
			@(negedge CLK);
			cycles++;
			if (cycles > 20) begin
				$display("timeout: reset never released");
				finishRun(1);
			end
		end
		for (int runIdx = 0; runIdx < numRuns; runIdx++) begin
			loadWindow(0);
			loadWindow(1);
			// cores idle, both rams read back
			readRange(1'b1, 0, 16);
			readRange(1'b1, `PROG_WINDOW, 16);
			readRange(1'b0, 16, 16);
			readRange(1'b0, `PROG_WINDOW + 16, 16);
			pulseStart();
			// run is high now, grant only after done
			hostAccess(1'b0, 1'b0, 8'(`PROG_WINDOW + 16), 8'h00);
			waitDone();
			readRange(1'b0, 16, 16);
			readRange(1'b0, `PROG_WINDOW + 16, 16);
		end
		finishRun(0);
	end

endmodule

/* dualCoreSystem.f */
+incdir+.
dualCorePkg.sv
syncRam.sv
memArbiter.sv
core.sv
runControl.sv
dualCoreSystem.sv
tbClock.sv
dualCoreChecker.sv
dualCoreSystemTb.sv

/* run.sh */
#!/bin/sh
# build and run the dual-core testbench with Verilator

logFile=sim.log

if ! verilator --binary --timing -f dualCoreSystem.f --top-module dualCoreSystemTb \
	-o dualCoreSim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/dualCoreSim > "$logFile" 2>&1; then
	cat "$logFile"
	echo "simulation exited with an error status"
	exit 1
fi

cat "$logFile"

if grep -q "^=== PASS ===$" "$logFile"; then
	exit 0
fi

echo "pass message not found in $logFile"
exit 1
